/* fir.f */
fir_data_pkg.sv
fir_reg_pkg.sv
fir_sram.sv
fir_axil_regs.sv
fir_mac_engine.sv
fir.sv
tb_fir_assertions.sv
tb_fir.sv

/* Makefile */
# Verilator build and run for the FIR filter testbench

VERILATOR ?= verilator
TOP       ?= tb_fir
RTL_TOP   ?= fir
FILELIST  ?= fir.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100
RTL_FILES ?= fir_data_pkg.sv fir_reg_pkg.sv fir_sram.sv fir_axil_regs.sv \
             fir_mac_engine.sv fir.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@grep -q '^\*\*\* PASSED \*\*\*$$' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_fir.sv */
`timescale 1ns/10ps

module tb_fir;

    localparam int NUM_TAPS    = 11;
    localparam int RUN_LEN     = 40;
    localparam int WAIT_LIMIT  = 200;
    localparam int DRAIN_LIMIT = 20000;
    localparam fir_reg_pkg::reg_data_t DONE_MASK = 32'h1 << fir_reg_pkg::CTRL_DONE_BIT;
    localparam fir_reg_pkg::reg_data_t IDLE_MASK = 32'h1 << fir_reg_pkg::CTRL_IDLE_BIT;

    logic                     axis_clk = 1'b0;
    logic                     axis_rst_n;
    logic                     awvalid;
    logic                     awready;
    fir_reg_pkg::reg_addr_t   awaddr;
    logic                     wvalid;
    logic                     wready;
    fir_reg_pkg::reg_data_t   wdata;
    logic                     arvalid;
    logic                     arready;
    fir_reg_pkg::reg_addr_t   araddr;
    logic                     rvalid;
    logic                     rready;
    fir_reg_pkg::reg_data_t   rdata;
    fir_data_pkg::axis_beat_t ss;
    logic                     ss_valid;
    logic                     ss_ready;
    fir_data_pkg::axis_beat_t sm;
    logic                     sm_valid;
    logic                     sm_ready;

    fir_data_pkg::coef_t      coefs [NUM_TAPS];
    fir_data_pkg::sample_t    samples [RUN_LEN];
    logic                     gap_pat [RUN_LEN];
    logic                     ready_pat [256];
    fir_data_pkg::axis_beat_t exp_q [$];
    logic [31:0]              lfsr_q = 32'he9d2_75fc;
    logic                     stall_en = 1'b0;
    int                       ready_pos = 0;
    int                       out_cnt = 0;
    int                       value_errs = 0;
    int                       timeout_errs = 0;

    fir #(
        .NUM_TAPS (NUM_TAPS)
    ) fir_i (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),
        .awready    (awready),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wready     (wready),
        .wdata      (wdata),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .ss         (ss),
        .ss_valid   (ss_valid),
        .ss_ready   (ss_ready),
        .sm         (sm),
        .sm_valid   (sm_valid),
        .sm_ready   (sm_ready)
    );

    always #4 axis_clk = ~axis_clk;

    // 32-bit Fibonacci LFSR with taps 32 22 2 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] lfsr_word(int width);
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < width; i++) begin
            w = {w[30:0], lfsr_bit()};
        end
        return w;
    endfunction

    // y[n] = sum of h[k]*x[n-k] with zero history before the run
    function automatic fir_data_pkg::sample_t fir_ref(int n);
        fir_data_pkg::sample_t sum;
        sum = '0;
        for (int k = 0; k < NUM_TAPS; k++) begin
            if (n - k >= 0) begin
                sum = sum + fir_data_pkg::sample_t'(coefs[k] * samples[n - k]);
            end
        end
        return sum;
    endfunction

    function automatic fir_reg_pkg::reg_addr_t tap_addr(int k);
        return fir_reg_pkg::reg_addr_t'(fir_reg_pkg::REG_TAP_BASE + 4 * k);
    endfunction

    // sink follows the random ready pattern while stalls are enabled
    always @(posedge axis_clk) begin
        logic en;
        en = stall_en;
        #1;
        if (en) begin
            sm_ready = ready_pat[ready_pos];
            ready_pos = (ready_pos + 1) % 256;
        end else begin
            sm_ready = 1'b1;
        end
    end

    // output checker
    always @(posedge axis_clk) begin
        fir_data_pkg::axis_beat_t exp_beat;
        if (axis_rst_n && sm_valid && sm_ready) begin
            if (exp_q.size() == 0) begin
                $display("unexpected output beat with data %h", sm.data);
                value_errs++;
            end else begin
                exp_beat = exp_q.pop_front();
                if (sm.data !== exp_beat.data) begin
                    $display("CHECK FAILED sm.data beat %0d got %h expected %h",
                             out_cnt, sm.data, exp_beat.data);
                    value_errs++;
                end
                if (sm.last !== exp_beat.last) begin
                    $display("CHECK FAILED sm.last beat %0d got %h expected %h",
                             out_cnt, sm.last, exp_beat.last);
                    value_errs++;
                end
            end
            out_cnt++;
        end
    end

    task automatic expect_value(input string name, input fir_reg_pkg::reg_data_t got,
                                input fir_reg_pkg::reg_data_t want);
        if (got !== want) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, want);
            value_errs++;
        end
    endtask

    task automatic write_reg(input fir_reg_pkg::reg_addr_t addr,
                             input fir_reg_pkg::reg_data_t data);
        int cyc;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        cyc = 0;
        @(posedge axis_clk);
        while (!awready && cyc < WAIT_LIMIT) begin
            @(posedge axis_clk);
            cyc++;
        end
        if (!awready) begin
            $display("timeout waiting for awready at address %h", addr);
            timeout_errs++;
        end else if (wready !== 1'b1) begin
            $display("CHECK FAILED wready at address %h got %h expected %h",
                     addr, wready, 1'b1);
            value_errs++;
        end
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
    endtask

    task automatic read_reg(input fir_reg_pkg::reg_addr_t addr,
                            output fir_reg_pkg::reg_data_t data);
        int cyc;
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b1;
        cyc = 0;
        @(posedge axis_clk);
        while (!arready && cyc < WAIT_LIMIT) begin
            @(posedge axis_clk);
            cyc++;
        end
        if (!arready) begin
            $display("timeout waiting for arready at address %h", addr);
            timeout_errs++;
        end
        #1;
        arvalid = 1'b0;
        cyc = 0;
        @(posedge axis_clk);
        while (!rvalid && cyc < WAIT_LIMIT) begin
            @(posedge axis_clk);
            cyc++;
        end
        if (!rvalid) begin
            $display("timeout waiting for rvalid at address %h", addr);
            timeout_errs++;
        end
        data = rdata;
        #1;
        rready = 1'b0;
    endtask

    // small signed coefficients
    task automatic make_taps();
        logic [31:0] w;
        for (int k = 0; k < NUM_TAPS; k++) begin
            w = lfsr_word(12);
            coefs[k] = {{20{w[11]}}, w[11:0]};
        end
    endtask

    task automatic make_samples();
        logic [31:0] w;
        for (int i = 0; i < RUN_LEN; i++) begin
            w = lfsr_word(16);
            samples[i] = {{16{w[15]}}, w[15:0]};
            gap_pat[i] = lfsr_bit();
        end
    endtask

    task automatic load_taps();
        for (int k = 0; k < NUM_TAPS; k++) begin
            write_reg(tap_addr(k), coefs[k]);
        end
    endtask

    task automatic check_taps();
        fir_reg_pkg::reg_data_t rd;
        for (int k = 0; k < NUM_TAPS; k++) begin
            read_reg(tap_addr(k), rd);
            expect_value($sformatf("rdata tap %0d", k), rd, coefs[k]);
        end
    endtask

    task automatic send_samples();
        int cyc;
        for (int i = 0; i < RUN_LEN; i++) begin
            // idle cycle before some beats
            if (gap_pat[i]) begin
                @(posedge axis_clk);
                #1;
            end
            ss.data  = samples[i];
            ss.last  = (i == RUN_LEN - 1);
            ss_valid = 1'b1;
            cyc = 0;
            @(posedge axis_clk);
            while (!ss_ready && cyc < WAIT_LIMIT) begin
                @(posedge axis_clk);
                cyc++;
            end
            if (!ss_ready) begin
                $display("timeout waiting for ss_ready on sample %0d", i);
                timeout_errs++;
            end
            #1;
            ss_valid = 1'b0;
        end
    endtask

    // bus traffic while the engine is busy
    task automatic probe_busy();
        fir_reg_pkg::reg_data_t rd;
        read_reg(fir_reg_pkg::REG_CTRL, rd);
        expect_value("rdata REG_CTRL during run", rd, '0);
        write_reg(tap_addr(3), ~coefs[3]);
        read_reg(tap_addr(3), rd);
        expect_value("rdata tap 3 during run", rd, '0);
    endtask

    task automatic wait_outputs();
        int cyc;
        cyc = 0;
        while (exp_q.size() != 0 && cyc < DRAIN_LIMIT) begin
            @(posedge axis_clk);
            #1;
            cyc++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout with %0d output beats still missing", exp_q.size());
            timeout_errs++;
            exp_q.delete();
        end
    endtask

    task automatic run_filter(input logic stall, input logic probe);
        fir_reg_pkg::reg_data_t   rd;
        fir_data_pkg::axis_beat_t b;
        for (int n = 0; n < RUN_LEN; n++) begin
            b.data = fir_ref(n);
            b.last = (n == RUN_LEN - 1);
            exp_q.push_back(b);
        end
        stall_en = stall;
        write_reg(fir_reg_pkg::REG_CTRL, 32'h1 << fir_reg_pkg::CTRL_START_BIT);
        fork
            send_samples();
            begin
                if (probe) begin
                    probe_busy();
                end
            end
        join
        wait_outputs();
        stall_en = 1'b0;
        read_reg(fir_reg_pkg::REG_CTRL, rd);
        expect_value("rdata REG_CTRL after run", rd, DONE_MASK | IDLE_MASK);
    endtask

    initial begin
        fir_reg_pkg::reg_data_t rd;
        int                     assert_errs;
        axis_rst_n = 1'b0;
        awvalid    = 1'b0;
        awaddr     = '0;
        wvalid     = 1'b0;
        wdata      = '0;
        arvalid    = 1'b0;
        araddr     = '0;
        rready     = 1'b0;
        ss         = '0;
        ss_valid   = 1'b0;
        sm_ready   = 1'b0;
        for (int i = 0; i < 256; i++) begin
            ready_pat[i] = lfsr_bit();
        end
        repeat (2) @(posedge axis_clk);
        #1;
        axis_rst_n = 1'b1;

        read_reg(fir_reg_pkg::REG_CTRL, rd);
        expect_value("rdata REG_CTRL after reset", rd, IDLE_MASK);
        make_taps();
        load_taps();
        write_reg(fir_reg_pkg::REG_LEN, RUN_LEN);
        check_taps();
        read_reg(fir_reg_pkg::REG_LEN, rd);
        expect_value("rdata REG_LEN", rd, RUN_LEN);

        // input gaps with the sink always ready
        make_samples();
        run_filter(1'b0, 1'b0);

        // new taps with back-pressure and bus access while busy
        make_taps();
        load_taps();
        make_samples();
        run_filter(1'b1, 1'b1);

        // blocked tap write must not show here
        check_taps();
        make_samples();
        run_filter(1'b1, 1'b0);

        assert_errs = fir_i.fir_assertions_i.fail_cnt;
        $display("errors: value %0d, timeout %0d, assertion %0d, outputs seen %0d",
                 value_errs, timeout_errs, assert_errs, out_cnt);
        if (value_errs == 0 && timeout_errs == 0 && assert_errs == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* tb_fir_assertions.sv */
`timescale 1ns/10ps

module fir_assertions (
    input logic                     axis_clk,
    input logic                     axis_rst_n,
    input fir_data_pkg::axis_beat_t sm,
    input logic                     sm_valid,
    input logic                     sm_ready,
    input logic                     ss_ready,
    input logic                     rvalid,
    input logic                     rready,
    input fir_reg_pkg::reg_data_t   rdata,
    input logic                     awready,
    input logic                     arready
);

    // number of failed assertions, read by the testbench
    int fail_cnt = 0;

    // output beat held until the sink takes it
    sm_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        sm_valid && !sm_ready |=> sm_valid && $stable(sm))
    else begin
        $error("sm_valid or sm changed before sm_ready");
        fail_cnt++;
    end

    // read response held until rready
    r_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata))
    else begin
        $error("rvalid or rdata changed before rready");
        fail_cnt++;
    end

    // one sample in flight at a time
    no_overlap: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        !(ss_ready && sm_valid))
    else begin
        $error("ss_ready and sm_valid high together");
        fail_cnt++;
    end

    // write wins over read
    wr_over_rd: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        !(awready && arready))
    else begin
        $error("awready and arready high together");
        fail_cnt++;
    end

endmodule

bind fir fir_assertions fir_assertions_i (
    .axis_clk   (axis_clk),
    .axis_rst_n (axis_rst_n),
    .sm         (sm),
    .sm_valid   (sm_valid),
    .sm_ready   (sm_ready),
    .ss_ready   (ss_ready),
    .rvalid     (rvalid),
    .rready     (rready),
    .rdata      (rdata),
    .awready    (awready),
    .arready    (arready)
);

/* fir.sv */
`timescale 1ns/10ps

module fir #(
    parameter int NUM_TAPS = 11
) (
    input  logic                      axis_clk,
    input  logic                      axis_rst_n,
    input  logic                      awvalid,
    output logic                      awready,
    input  fir_reg_pkg::reg_addr_t    awaddr,
    input  logic                      wvalid,
    output logic                      wready,
    input  fir_reg_pkg::reg_data_t    wdata,
    input  logic                      arvalid,
    output logic                      arready,
    input  fir_reg_pkg::reg_addr_t    araddr,
    output logic                      rvalid,
    input  logic                      rready,
    output fir_reg_pkg::reg_data_t    rdata,
    input  fir_data_pkg::axis_beat_t  ss,
    input  logic                      ss_valid,
    output logic                      ss_ready,
    output fir_data_pkg::axis_beat_t  sm,
    output logic                      sm_valid,
    input  logic                      sm_ready
);

    fir_data_pkg::tap_wr_t  tap_wr;
    fir_data_pkg::tap_idx_t cfg_rd_idx;
    fir_data_pkg::tap_idx_t tap_rd_idx;
    fir_data_pkg::coef_t    tap_rd_data;
    fir_data_pkg::tap_idx_t hist_wr_idx;
    fir_data_pkg::tap_idx_t hist_rd_idx;
    fir_data_pkg::sample_t  hist_wr_data;
    fir_data_pkg::sample_t  hist_rd_data;
    logic                   hist_wr_en;
    logic                   start;
    logic                   done;
    logic                   busy;

    fir_axil_regs #(
        .NUM_TAPS (NUM_TAPS)
    ) regs_i (
        .axis_clk    (axis_clk),
        .axis_rst_n  (axis_rst_n),
        .awvalid     (awvalid),
        .awready     (awready),
        .awaddr      (awaddr),
        .wvalid      (wvalid),
        .wready      (wready),
        .wdata       (wdata),
        .arvalid     (arvalid),
        .arready     (arready),
        .araddr      (araddr),
        .rvalid      (rvalid),
        .rready      (rready),
        .rdata       (rdata),
        .tap_wr      (tap_wr),
        .cfg_rd_idx  (cfg_rd_idx),
        .tap_rd_data (tap_rd_data),
        .start       (start),
        .done        (done),
        .busy        (busy)
    );

    fir_mac_engine #(
        .NUM_TAPS (NUM_TAPS)
    ) engine_i (
        .axis_clk     (axis_clk),
        .axis_rst_n   (axis_rst_n),
        .start        (start),
        .done         (done),
        .busy         (busy),
        .ss           (ss),
        .ss_valid     (ss_valid),
        .ss_ready     (ss_ready),
        .sm           (sm),
        .sm_valid     (sm_valid),
        .sm_ready     (sm_ready),
        .cfg_rd_idx   (cfg_rd_idx),
        .tap_rd_idx   (tap_rd_idx),
        .tap_rd_data  (tap_rd_data),
        .hist_wr_en   (hist_wr_en),
        .hist_wr_idx  (hist_wr_idx),
        .hist_wr_data (hist_wr_data),
        .hist_rd_idx  (hist_rd_idx),
        .hist_rd_data (hist_rd_data)
    );

    // coefficients, written by the host and read by the engine
    fir_sram #(
        .NUM_TAPS   (NUM_TAPS),
        .DATA_WIDTH ($bits(fir_data_pkg::coef_t))
    ) tap_ram_i (
        .axis_clk (axis_clk),
        .wr_en    (tap_wr.en),
        .wr_idx   (tap_wr.idx),
        .wr_data  (tap_wr.data),
        .rd_idx   (tap_rd_idx),
        .rd_data  (tap_rd_data)
    );

    // sample history ring
    fir_sram #(
        .NUM_TAPS   (NUM_TAPS),
        .DATA_WIDTH ($bits(fir_data_pkg::sample_t))
    ) hist_ram_i (
        .axis_clk (axis_clk),
        .wr_en    (hist_wr_en),
        .wr_idx   (hist_wr_idx),
        .wr_data  (hist_wr_data),
        .rd_idx   (hist_rd_idx),
        .rd_data  (hist_rd_data)
    );

endmodule

/* fir_mac_engine.sv */
`timescale 1ns/10ps

module fir_mac_engine #(
    parameter int NUM_TAPS = 11
) (
    input  logic                       axis_clk,
    input  logic                       axis_rst_n,
    input  logic                       start,
    output logic                       done,
    output logic                       busy,
    // input stream
    input  fir_data_pkg::axis_beat_t   ss,
    input  logic                       ss_valid,
    output logic                       ss_ready,
    // output stream
    output fir_data_pkg::axis_beat_t   sm,
    output logic                       sm_valid,
    input  logic                       sm_ready,
    // tap memory read port
    input  fir_data_pkg::tap_idx_t     cfg_rd_idx,
    output fir_data_pkg::tap_idx_t     tap_rd_idx,
    input  fir_data_pkg::coef_t        tap_rd_data,
    // history ring
    output logic                       hist_wr_en,
    output fir_data_pkg::tap_idx_t     hist_wr_idx,
    output fir_data_pkg::sample_t      hist_wr_data,
    output fir_data_pkg::tap_idx_t     hist_rd_idx,
    input  fir_data_pkg::sample_t      hist_rd_data
);

    localparam fir_data_pkg::tap_idx_t LAST_IDX = fir_data_pkg::tap_idx_t'(NUM_TAPS - 1);

    fir_data_pkg::engine_state_t state;
    fir_data_pkg::tap_idx_t      tap_cnt;
    fir_data_pkg::tap_idx_t      head;
    fir_data_pkg::sample_t       acc;
    fir_data_pkg::sample_t       product;
    logic                        last_q;
    logic                        drain_q;
    logic                        rd_vld_q;
    logic                        rd_first_q;
    logic                        issue;
    logic                        accept;
    logic [4:0]                  back_pos;

    assign busy     = (state != fir_data_pkg::E_IDLE);
    assign ss_ready = (state == fir_data_pkg::E_ACCEPT);
    assign sm_valid = (state == fir_data_pkg::E_OUT);
    assign accept   = ss_ready && ss_valid;
    assign done     = sm_valid && sm_ready && last_q;

    // one tap/history read pair per cycle until the last tap is issued
    assign issue = (state == fir_data_pkg::E_MAC) && !drain_q;

    // host reads reach the tap memory only between runs
    assign tap_rd_idx = busy ? tap_cnt : cfg_rd_idx;

    // slot tap_cnt places behind the head, modulo NUM_TAPS
    always_comb begin
        back_pos = {1'b0, head} + 5'(NUM_TAPS) - {1'b0, tap_cnt};
        if (back_pos >= 5'(NUM_TAPS)) begin
            back_pos = back_pos - 5'(NUM_TAPS);
        end
        hist_rd_idx = back_pos[3:0];
    end

    // zero the ring in E_CLEAR, otherwise store the new sample at the head
    assign hist_wr_en   = (state == fir_data_pkg::E_CLEAR) || accept;
    assign hist_wr_idx  = (state == fir_data_pkg::E_CLEAR) ? tap_cnt : head;
    assign hist_wr_data = (state == fir_data_pkg::E_CLEAR) ? '0 : ss.data;

    // wraps to 32 bits
    assign product = fir_data_pkg::sample_t'(tap_rd_data * hist_rd_data);

    assign sm.data = acc;
    assign sm.last = last_q;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state      <= fir_data_pkg::E_IDLE;
            tap_cnt    <= '0;
            head       <= '0;
            drain_q    <= 1'b0;
            rd_vld_q   <= 1'b0;
            rd_first_q <= 1'b0;
        end else begin
            rd_vld_q   <= issue;
            rd_first_q <= issue && (tap_cnt == '0);
            case (state)
                fir_data_pkg::E_IDLE: begin
                    tap_cnt <= '0;
                    head    <= '0;
                    if (start) begin
                        state <= fir_data_pkg::E_CLEAR;
                    end
                end
                fir_data_pkg::E_CLEAR: begin
                    if (tap_cnt == LAST_IDX) begin
                        tap_cnt <= '0;
                        state   <= fir_data_pkg::E_ACCEPT;
                    end else begin
                        tap_cnt <= tap_cnt + 1'b1;
                    end
                end
                fir_data_pkg::E_ACCEPT: begin
                    if (ss_valid) begin
                        state <= fir_data_pkg::E_MAC;
                    end
                end
                fir_data_pkg::E_MAC: begin
                    if (drain_q) begin
                        // last product lands this cycle
                        drain_q <= 1'b0;
                        state   <= fir_data_pkg::E_OUT;
                    end else if (tap_cnt == LAST_IDX) begin
                        drain_q <= 1'b1;
                        tap_cnt <= '0;
                    end else begin
                        tap_cnt <= tap_cnt + 1'b1;
                    end
                end
                fir_data_pkg::E_OUT: begin
                    if (sm_ready) begin
                        head  <= (head == LAST_IDX) ? '0 : head + 1'b1;
                        state <= last_q ? fir_data_pkg::E_IDLE : fir_data_pkg::E_ACCEPT;
                    end
                end
                default: begin
                    state <= fir_data_pkg::E_IDLE;
                end
            endcase
        end
    end

    // accumulator and last flag, held while E_OUT waits for sm_ready
    always_ff @(posedge axis_clk) begin
        if (accept) begin
            last_q <= ss.last;
        end
        if (rd_vld_q) begin
            acc <= (rd_first_q ? '0 : acc) + product;
        end
    end

endmodule

/* fir_axil_regs.sv */
`timescale 1ns/10ps

module fir_axil_regs #(
    parameter int NUM_TAPS = 11
) (
    input  logic                     axis_clk,
    input  logic                     axis_rst_n,
    // write address and data
    input  logic                     awvalid,
    output logic                     awready,
    input  fir_reg_pkg::reg_addr_t   awaddr,
    input  logic                     wvalid,
    output logic                     wready,
    input  fir_reg_pkg::reg_data_t   wdata,
    // read address and data
    input  logic                     arvalid,
    output logic                     arready,
    input  fir_reg_pkg::reg_addr_t   araddr,
    output logic                     rvalid,
    input  logic                     rready,
    output fir_reg_pkg::reg_data_t   rdata,
    // tap memory and engine side
    output fir_data_pkg::tap_wr_t    tap_wr,
    output fir_data_pkg::tap_idx_t   cfg_rd_idx,
    input  fir_data_pkg::coef_t      tap_rd_data,
    output logic                     start,
    input  logic                     done,
    input  logic                     busy
);

    fir_reg_pkg::axil_state_t state;
    fir_reg_pkg::reg_data_t   len_q;
    fir_reg_pkg::reg_data_t   rd_value;
    logic                     ap_done;
    logic                     ap_idle;
    logic                     wr_acc;
    logic                     rd_acc;
    logic                     rd_tap;

    // true when the address falls on one of the NUM_TAPS coefficient words
    function automatic logic tap_hit(fir_reg_pkg::reg_addr_t addr);
        fir_reg_pkg::reg_addr_t off;
        off = addr - fir_reg_pkg::REG_TAP_BASE;
        return (addr >= fir_reg_pkg::REG_TAP_BASE) && (off[1:0] == 2'b00) &&
               ((off >> 2) < NUM_TAPS);
    endfunction

    function automatic fir_data_pkg::tap_idx_t tap_index(fir_reg_pkg::reg_addr_t addr);
        fir_reg_pkg::reg_addr_t off;
        off = (addr - fir_reg_pkg::REG_TAP_BASE) >> 2;
        return fir_data_pkg::tap_idx_t'(off);
    endfunction

    // writes win over reads in the same cycle
    assign wr_acc  = (state == fir_reg_pkg::L_IDLE) && awvalid && wvalid;
    assign rd_acc  = (state == fir_reg_pkg::L_IDLE) && arvalid && !wr_acc;
    assign awready = wr_acc;
    assign wready  = wr_acc;
    assign arready = rd_acc;

    // tap reads go through the memory only when the engine is idle
    assign rd_tap = tap_hit(araddr) && !busy;

    // memory is addressed while arready is up, data shows in L_TAP_READ
    assign cfg_rd_idx = tap_index(araddr);

    assign tap_wr.en   = wr_acc && tap_hit(awaddr) && !busy;
    assign tap_wr.idx  = tap_index(awaddr);
    assign tap_wr.data = fir_data_pkg::coef_t'(wdata);

    assign start = wr_acc && (awaddr == fir_reg_pkg::REG_CTRL) &&
                   wdata[fir_reg_pkg::CTRL_START_BIT] && ap_idle;

    always_comb begin
        rd_value = '0;
        if (araddr == fir_reg_pkg::REG_CTRL) begin
            rd_value[fir_reg_pkg::CTRL_DONE_BIT] = ap_done;
            rd_value[fir_reg_pkg::CTRL_IDLE_BIT] = ap_idle;
        end else if (araddr == fir_reg_pkg::REG_LEN) begin
            rd_value = len_q;
        end
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state  <= fir_reg_pkg::L_IDLE;
            rvalid <= 1'b0;
        end else begin
            case (state)
                fir_reg_pkg::L_IDLE: begin
                    if (rd_acc) begin
                        if (rd_tap) begin
                            state <= fir_reg_pkg::L_TAP_READ;
                        end else begin
                            state  <= fir_reg_pkg::L_RESP;
                            rvalid <= 1'b1;
                        end
                    end
                end
                fir_reg_pkg::L_TAP_READ: begin
                    state  <= fir_reg_pkg::L_RESP;
                    rvalid <= 1'b1;
                end
                fir_reg_pkg::L_RESP: begin
                    if (rready) begin
                        state  <= fir_reg_pkg::L_IDLE;
                        rvalid <= 1'b0;
                    end
                end
                default: begin
                    state  <= fir_reg_pkg::L_IDLE;
                    rvalid <= 1'b0;
                end
            endcase
        end
    end

    // held stable through L_RESP
    always_ff @(posedge axis_clk) begin
        if (rd_acc) begin
            rdata <= rd_value;
        end else if (state == fir_reg_pkg::L_TAP_READ) begin
            rdata <= fir_reg_pkg::reg_data_t'(tap_rd_data);
        end
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            len_q <= '0;
        end else if (wr_acc && (awaddr == fir_reg_pkg::REG_LEN)) begin
            len_q <= wdata;
        end
    end

    // idle after reset, busy from start until the last output leaves
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            ap_idle <= 1'b1;
            ap_done <= 1'b0;
        end else if (start) begin
            ap_idle <= 1'b0;
            ap_done <= 1'b0;
        end else if (done) begin
            ap_idle <= 1'b1;
            ap_done <= 1'b1;
        end
    end

endmodule

/* fir_sram.sv */
`timescale 1ns/10ps

module fir_sram #(
    parameter int NUM_TAPS   = 11,
    parameter int DATA_WIDTH = 32
) (
    input  logic                   axis_clk,
    input  logic                   wr_en,
    input  fir_data_pkg::tap_idx_t wr_idx,
    input  logic [DATA_WIDTH-1:0]  wr_data,
    input  fir_data_pkg::tap_idx_t rd_idx,
    output logic [DATA_WIDTH-1:0]  rd_data
);

    // one word per tap
    logic [DATA_WIDTH-1:0] mem [NUM_TAPS];

    always_ff @(posedge axis_clk) begin
        if (wr_en) begin
            mem[wr_idx] <= wr_data;
        end
    end

    // registered read, data one cycle after the address
    always_ff @(posedge axis_clk) begin
        rd_data <= mem[rd_idx];
    end

endmodule

/* fir_reg_pkg.sv */
package fir_reg_pkg;

    // byte address on the AXI4-Lite bus
    typedef logic [11:0] reg_addr_t;

    typedef logic [31:0] reg_data_t;

    // register map
    localparam reg_addr_t REG_CTRL     = 12'h000;
    localparam reg_addr_t REG_LEN      = 12'h010;
    // tap k lives at REG_TAP_BASE + 4*k
    localparam reg_addr_t REG_TAP_BASE = 12'h020;

    // control and status bits in REG_CTRL
    localparam int CTRL_START_BIT = 0;
    localparam int CTRL_DONE_BIT  = 1;
    localparam int CTRL_IDLE_BIT  = 2;

    // read side of the slave, writes finish in L_IDLE
    typedef enum logic [1:0] {
        L_IDLE,
        L_TAP_READ,
        L_RESP
    } axil_state_t;

endpackage

/* fir_data_pkg.sv */
package fir_data_pkg;

    // stream sample and accumulator, products and sums wrap to 32 bits
    typedef logic signed [31:0] sample_t;

    // filter coefficient
    typedef logic signed [31:0] coef_t;

    // tap or history slot index, good for up to 16 taps
    typedef logic [3:0] tap_idx_t;

    // one stream beat, same layout on input and output
    typedef struct packed {
        sample_t data;
        logic    last;
    } axis_beat_t;

    // coefficient write into the tap memory
    typedef struct packed {
        logic     en;
        tap_idx_t idx;
        coef_t    data;
    } tap_wr_t;

    typedef enum logic [2:0] {
        E_IDLE,
        E_CLEAR,
        E_ACCEPT,
        E_MAC,
        E_OUT
    } engine_state_t;

endpackage
